/* rtl/system_pkg.sv */
`default_nettype none

package system_pkg;

	// cpu bus widths
	localparam int addr_width = 16;
	localparam int data_width = 8;

	// where a cpu address lands
	typedef enum logic [3:0] {
		region_pgrom,
		region_wkram,
		region_in0,
		region_video_ctl,
		region_joystick,
		region_analog_l,
		region_spinner,
		region_sq1,
		region_sq2,
		region_wave,
		region_noise,
		region_pause,
		region_menu,
		region_poly_en,
		region_none
	} region_t;

	// single-byte registers
	localparam logic [addr_width-1:0] in0_addr = 16'h8000;
	localparam logic [addr_width-1:0] video_ctl_addr = 16'h8001;
	localparam logic [addr_width-1:0] pause_addr = 16'h8A30;
	localparam logic [addr_width-1:0] menu_addr = 16'h8A31;
	localparam logic [addr_width-1:0] poly_en_addr = 16'h8A32;

	// input pages, matched on addr[15:8]
	localparam logic [7:0] joystick_page = 8'h81;
	localparam logic [7:0] analog_l_page = 8'h82;
	localparam logic [7:0] spinner_page = 8'h85;
	localparam logic [7:0] sq1_page = 8'h86;
	localparam logic [7:0] sq2_page = 8'h87;
	localparam logic [7:0] wave_page = 8'h88;
	localparam logic [7:0] noise_page = 8'h89;

	// work ram sits at 0xc000 and up
	localparam logic [1:0] wkram_base_bits = 2'd3;

	// packed input words
	localparam int joystick_bits = 192;
	localparam int analog_l_bits = 256;
	localparam int spinner_bits = 96;
	localparam int sound_word_bits = 11;

	// blue high, then green, red low
	typedef logic [23:0] rgb_t;

endpackage

`default_nettype wire

/* rtl/address_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module address_decoder (
	input wire [system_pkg::addr_width-1:0] cpu_addr,
	output system_pkg::region_t region,
	output logic [5:0] byte_index
);

	// upper byte selects the input page
	logic [7:0] page;

	assign page = cpu_addr[15:8];

	// offset inside a page
	assign byte_index = cpu_addr[5:0];

	always_comb
	begin
		// lower half of the map is program rom
		if (!cpu_addr[15])
			region = system_pkg::region_pgrom;
		else if (cpu_addr[15:14] == system_pkg::wkram_base_bits)
			region = system_pkg::region_wkram;
		// exact addresses first
		else if (cpu_addr == system_pkg::in0_addr)
			region = system_pkg::region_in0;
		else if (cpu_addr == system_pkg::video_ctl_addr)
			region = system_pkg::region_video_ctl;
		else if (cpu_addr == system_pkg::pause_addr)
			region = system_pkg::region_pause;
		else if (cpu_addr == system_pkg::menu_addr)
			region = system_pkg::region_menu;
		else if (cpu_addr == system_pkg::poly_en_addr)
			region = system_pkg::region_poly_en;
		// then whole pages
		else if (page == system_pkg::joystick_page)
			region = system_pkg::region_joystick;
		else if (page == system_pkg::analog_l_page)
			region = system_pkg::region_analog_l;
		else if (page == system_pkg::spinner_page)
			region = system_pkg::region_spinner;
		else if (page == system_pkg::sq1_page)
			region = system_pkg::region_sq1;
		else if (page == system_pkg::sq2_page)
			region = system_pkg::region_sq2;
		else if (page == system_pkg::wave_page)
			region = system_pkg::region_wave;
		else if (page == system_pkg::noise_page)
			region = system_pkg::region_noise;
		else
			region = system_pkg::region_none;
	end

endmodule

`default_nettype wire

/* rtl/system_control.sv */
`timescale 1ns/1ps
`default_nettype none

module system_control (
	input wire clk_24,
	input wire arst_n,
	input wire system_pkg::region_t region,
	input wire cpu_wr_n,
	input wire [system_pkg::data_width-1:0] cpu_dout,
	input wire pause,
	input wire menu,
	output logic pause_system,
	output logic sprite_layer_high,
	output logic menu_trigger
);

	logic [system_pkg::data_width-1:0] video_control;
	logic pause_trigger;

	// either source holds the system
	assign pause_system = pause || pause_trigger;

	// bit 0 puts sprites above the character map
	assign sprite_layer_high = video_control[0];

	always_ff @(posedge clk_24 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			video_control <= '0;
			pause_trigger <= 1'b0;
			menu_trigger <= 1'b0;
		end
		else
		begin
			if (!cpu_wr_n && region == system_pkg::region_video_ctl)
				video_control <= cpu_dout;
			// cpu requests pause, external pause releases it
			if (!cpu_wr_n && region == system_pkg::region_pause)
				pause_trigger <= 1'b1;
			if (pause)
				pause_trigger <= 1'b0;
			// menu button latches, cpu acknowledges by writing
			if (menu)
				menu_trigger <= 1'b1;
			if (!cpu_wr_n && region == system_pkg::region_menu)
				menu_trigger <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* rtl/memory_block.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_block #(
	parameter int pgrom_addr_bits = 15,
	parameter int wkram_addr_bits = 14
) (
	input wire clk_24,
	input wire system_pkg::region_t region,
	input wire cpu_wr_n,
	input wire [system_pkg::addr_width-1:0] cpu_addr,
	input wire [system_pkg::data_width-1:0] cpu_dout,
	input wire dn_wr,
	input wire [7:0] dn_index,
	input wire [16:0] dn_addr,
	input wire [system_pkg::data_width-1:0] dn_data,
	output logic [system_pkg::data_width-1:0] pgrom_q,
	output logic [system_pkg::data_width-1:0] wkram_q
);

	logic [system_pkg::data_width-1:0] pgrom [0:(1 << pgrom_addr_bits)-1];
	logic [system_pkg::data_width-1:0] wkram [0:(1 << wkram_addr_bits)-1];
	logic pgrom_wr;
	logic wkram_wr;

	// download target 0 is the program rom
	assign pgrom_wr = dn_wr && (dn_index == 8'd0);
	assign wkram_wr = !cpu_wr_n && (region == system_pkg::region_wkram);

	// program rom, download writes on one side, cpu reads on the other
	always_ff @(posedge clk_24)
	begin
		if (pgrom_wr)
			pgrom[dn_addr[pgrom_addr_bits-1:0]] <= dn_data;
		pgrom_q <= pgrom[cpu_addr[pgrom_addr_bits-1:0]];
	end

	// work ram, single port, read returns old contents
	always_ff @(posedge clk_24)
	begin
		if (wkram_wr)
			wkram[cpu_addr[wkram_addr_bits-1:0]] <= cpu_dout;
		wkram_q <= wkram[cpu_addr[wkram_addr_bits-1:0]];
	end

endmodule

`default_nettype wire

/* rtl/cpu_read_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_read_mux (
	input wire clk_24,
	input wire arst_n,
	input wire system_pkg::region_t region,
	input wire [5:0] byte_index,
	input wire [system_pkg::joystick_bits-1:0] joystick,
	input wire [system_pkg::analog_l_bits-1:0] analog_l,
	input wire [system_pkg::spinner_bits-1:0] spinner,
	input wire [system_pkg::sound_word_bits-1:0] sq1,
	input wire [system_pkg::sound_word_bits-1:0] sq2,
	input wire [system_pkg::sound_word_bits-1:0] wave,
	input wire [system_pkg::sound_word_bits-1:0] noise,
	input wire hs,
	input wire vs,
	input wire hb,
	input wire vb,
	input wire menu,
	input wire menu_trigger,
	input wire poly_en,
	input wire [system_pkg::data_width-1:0] pgrom_q,
	input wire [system_pkg::data_width-1:0] wkram_q,
	output logic [system_pkg::data_width-1:0] cpu_din
);

	localparam int joystick_bytes = system_pkg::joystick_bits / 8;
	localparam int analog_l_bytes = system_pkg::analog_l_bits / 8;
	localparam int spinner_bytes = system_pkg::spinner_bits / 8;

	system_pkg::region_t region_q;
	logic [system_pkg::data_width-1:0] byte_sel;
	logic [system_pkg::data_width-1:0] byte_q;

	// low byte or zero-padded high byte of a sound status word
	function automatic logic [7:0] sound_byte(
		input logic [system_pkg::sound_word_bits-1:0] word,
		input logic hi
	);
		if (hi)
			sound_byte = {{(16 - system_pkg::sound_word_bits){1'b0}},
				word[system_pkg::sound_word_bits-1:8]};
		else
			sound_byte = word[7:0];
	endfunction

	// slice the addressed input byte
	always_comb
	begin
		byte_sel = '0;
		case (region)
			system_pkg::region_in0:
				byte_sel = {hs, vs, hb, vb, 2'b10, menu, 1'b0};
			// indexes beyond the packed words read zero
			system_pkg::region_joystick:
				if (byte_index[4:0] < joystick_bytes)
					byte_sel = joystick[{byte_index[4:0], 3'd0} +: 8];
			system_pkg::region_analog_l:
				if (byte_index < analog_l_bytes)
					byte_sel = analog_l[{byte_index[4:0], 3'd0} +: 8];
			system_pkg::region_spinner:
				if (byte_index[3:0] < spinner_bytes)
					byte_sel = spinner[{byte_index[3:0], 3'd0} +: 8];
			system_pkg::region_sq1:
				byte_sel = sound_byte(sq1, byte_index[0]);
			system_pkg::region_sq2:
				byte_sel = sound_byte(sq2, byte_index[0]);
			system_pkg::region_wave:
				byte_sel = sound_byte(wave, byte_index[0]);
			system_pkg::region_noise:
				byte_sel = sound_byte(noise, byte_index[0]);
			system_pkg::region_menu:
				byte_sel = {8{menu_trigger}};
			system_pkg::region_poly_en:
				byte_sel = {8{poly_en}};
			default:
				byte_sel = '0;
		endcase
	end

	// one cycle stage, lines up with the memory reads
	always_ff @(posedge clk_24 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			region_q <= system_pkg::region_none;
			byte_q <= '0;
		end
		else
		begin
			region_q <= region;
			byte_q <= byte_sel;
		end
	end

	always_comb
	begin
		case (region_q)
			system_pkg::region_pgrom:
				cpu_din = pgrom_q;
			system_pkg::region_wkram:
				cpu_din = wkram_q;
			default:
				cpu_din = byte_q;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/layer_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

module layer_mixer (
	input wire sprite_layer_high,
	input wire system_pkg::rgb_t char_rgb,
	input wire system_pkg::rgb_t sprite_rgb,
	input wire system_pkg::rgb_t tile_rgb,
	input wire char_a,
	input wire sprite_a,
	input wire tile_a,
	input wire [system_pkg::data_width-1:0] star_grey,
	input wire hb,
	input wire vb,
	output logic [system_pkg::data_width-1:0] vga_r,
	output logic [system_pkg::data_width-1:0] vga_g,
	output logic [system_pkg::data_width-1:0] vga_b
);

	system_pkg::rgb_t star_rgb;
	system_pkg::rgb_t rgb_final;
	logic de;

	// stars are grey
	assign star_rgb = {3{star_grey}};

	always_comb
	begin
		// sprites above chars
		if (sprite_layer_high)
			rgb_final = sprite_a ? sprite_rgb :
				char_a ? char_rgb :
				tile_a ? tile_rgb : star_rgb;
		// chars above sprites
		else
			rgb_final = char_a ? char_rgb :
				sprite_a ? sprite_rgb :
				tile_a ? tile_rgb : star_rgb;
	end

	// black outside the active area
	assign de = !(hb || vb);
	assign vga_r = de ? rgb_final[7:0] : '0;
	assign vga_g = de ? rgb_final[15:8] : '0;
	assign vga_b = de ? rgb_final[23:16] : '0;

endmodule

`default_nettype wire

/* rtl/system_core.sv */
`timescale 1ns/1ps
`default_nettype none

module system_core #(
	parameter int pgrom_addr_bits = 15,
	parameter int wkram_addr_bits = 14
) (
	input wire clk_24,
	input wire arst_n,
	// processor bus
	input wire [system_pkg::addr_width-1:0] cpu_addr,
	input wire [system_pkg::data_width-1:0] cpu_dout,
	input wire cpu_wr_n,
	output logic [system_pkg::data_width-1:0] cpu_din,
	// rom download
	input wire dn_wr,
	input wire [7:0] dn_index,
	input wire [16:0] dn_addr,
	input wire [system_pkg::data_width-1:0] dn_data,
	// system inputs
	input wire pause,
	input wire menu,
	input wire poly_en,
	input wire [system_pkg::joystick_bits-1:0] joystick,
	input wire [system_pkg::analog_l_bits-1:0] analog_l,
	input wire [system_pkg::spinner_bits-1:0] spinner,
	input wire [system_pkg::sound_word_bits-1:0] sq1,
	input wire [system_pkg::sound_word_bits-1:0] sq2,
	input wire [system_pkg::sound_word_bits-1:0] wave,
	input wire [system_pkg::sound_word_bits-1:0] noise,
	// sync and blanking
	input wire hs,
	input wire vs,
	input wire hb,
	input wire vb,
	// video layers
	input wire system_pkg::rgb_t char_rgb,
	input wire char_a,
	input wire system_pkg::rgb_t sprite_rgb,
	input wire sprite_a,
	input wire system_pkg::rgb_t tile_rgb,
	input wire tile_a,
	input wire [system_pkg::data_width-1:0] star_grey,
	output logic pause_system,
	output logic [system_pkg::data_width-1:0] vga_r,
	output logic [system_pkg::data_width-1:0] vga_g,
	output logic [system_pkg::data_width-1:0] vga_b
);

	system_pkg::region_t region;
	logic [5:0] byte_index;
	logic sprite_layer_high;
	logic menu_trigger;
	logic [system_pkg::data_width-1:0] pgrom_q;
	logic [system_pkg::data_width-1:0] wkram_q;

	address_decoder u_decoder (
		.cpu_addr(cpu_addr),
		.region(region),
		.byte_index(byte_index)
	);

	system_control u_control (
		.clk_24(clk_24),
		.arst_n(arst_n),
		.region(region),
		.cpu_wr_n(cpu_wr_n),
		.cpu_dout(cpu_dout),
		.pause(pause),
		.menu(menu),
		.pause_system(pause_system),
		.sprite_layer_high(sprite_layer_high),
		.menu_trigger(menu_trigger)
	);

	memory_block #(
		.pgrom_addr_bits(pgrom_addr_bits),
		.wkram_addr_bits(wkram_addr_bits)
	) u_memory (
		.clk_24(clk_24),
		.region(region),
		.cpu_wr_n(cpu_wr_n),
		.cpu_addr(cpu_addr),
		.cpu_dout(cpu_dout),
		.dn_wr(dn_wr),
		.dn_index(dn_index),
		.dn_addr(dn_addr),
		.dn_data(dn_data),
		.pgrom_q(pgrom_q),
		.wkram_q(wkram_q)
	);

	// every read source arrives one cycle after the address
	cpu_read_mux u_read_mux (
		.clk_24(clk_24),
		.arst_n(arst_n),
		.region(region),
		.byte_index(byte_index),
		.joystick(joystick),
		.analog_l(analog_l),
		.spinner(spinner),
		.sq1(sq1),
		.sq2(sq2),
		.wave(wave),
		.noise(noise),
		.hs(hs),
		.vs(vs),
		.hb(hb),
		.vb(vb),
		.menu(menu),
		.menu_trigger(menu_trigger),
		.poly_en(poly_en),
		.pgrom_q(pgrom_q),
		.wkram_q(wkram_q),
		.cpu_din(cpu_din)
	);

	layer_mixer u_mixer (
		.sprite_layer_high(sprite_layer_high),
		.char_rgb(char_rgb),
		.sprite_rgb(sprite_rgb),
		.tile_rgb(tile_rgb),
		.char_a(char_a),
		.sprite_a(sprite_a),
		.tile_a(tile_a),
		.star_grey(star_grey),
		.hb(hb),
		.vb(vb),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b)
	);

endmodule

`default_nettype wire

/* testbench/system_core_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module system_core_assertions (
	input wire clk_24,
	input wire arst_n,
	input wire [system_pkg::addr_width-1:0] cpu_addr,
	input wire [system_pkg::data_width-1:0] cpu_din,
	input wire pause,
	input wire pause_system,
	input wire hb,
	input wire vb,
	input wire [system_pkg::data_width-1:0] vga_r,
	input wire [system_pkg::data_width-1:0] vga_g,
	input wire [system_pkg::data_width-1:0] vga_b
);

	// failed assertions so far, read back by the testbench
	int failures = 0;
	// previous address was rom or work ram, whose cells start undefined
	logic mem_read_q;

	always_ff @(posedge clk_24 or negedge arst_n)
	begin
		if (!arst_n)
			mem_read_q <= 1'b0;
		else
			mem_read_q <= !cpu_addr[15] || (cpu_addr[15:14] == system_pkg::wkram_base_bits);
	end

	// nothing visible during blanking
	blank_is_black: assert property (@(posedge clk_24)
		(hb || vb) |-> (vga_r == '0 && vga_g == '0 && vga_b == '0))
	else
	begin
		failures++;
		$error("video output not black during blanking");
	end

	// external pause always reaches the system
	pause_reaches_system: assert property (@(posedge clk_24) disable iff (!arst_n)
		pause |-> pause_system)
	else
	begin
		failures++;
		$error("pause input high but pause_system low");
	end

	// register sourced read data is always defined
	din_known: assert property (@(posedge clk_24) disable iff (!arst_n)
		!mem_read_q |-> !$isunknown(cpu_din))
	else
	begin
		failures++;
		$error("cpu_din has unknown bits");
	end

endmodule

`default_nettype wire

/* testbench/tb_system_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_system_core;

	localparam int clk_period = 4;
	// row kinds of the operation table
	localparam int k_write = 0;
	localparam int k_read = 1;
	localparam int k_load = 2;
	localparam int k_load_other = 3;
	localparam int k_pause_pulse = 4;
	localparam int k_menu_pulse = 5;
	localparam int k_pause_check = 6;
	localparam int k_poly = 7;
	localparam int k_mix = 8;
	localparam int k_status_in = 9;
	// hs, vs, hb, vb while the bus is exercised
	localparam logic [3:0] sync_idle = 4'b1001;

	logic clk_24;
	logic arst_n;
	logic [system_pkg::addr_width-1:0] cpu_addr;
	logic [system_pkg::data_width-1:0] cpu_dout;
	logic cpu_wr_n;
	logic [system_pkg::data_width-1:0] cpu_din;
	logic dn_wr;
	logic [7:0] dn_index;
	logic [16:0] dn_addr;
	logic [7:0] dn_data;
	logic pause;
	logic menu;
	logic poly_en;
	logic [system_pkg::joystick_bits-1:0] joystick;
	logic [system_pkg::analog_l_bits-1:0] analog_l;
	logic [system_pkg::spinner_bits-1:0] spinner;
	logic [system_pkg::sound_word_bits-1:0] sq1;
	logic [system_pkg::sound_word_bits-1:0] sq2;
	logic [system_pkg::sound_word_bits-1:0] wave;
	logic [system_pkg::sound_word_bits-1:0] noise;
	logic hs;
	logic vs;
	logic hb;
	logic vb;
	system_pkg::rgb_t char_rgb;
	logic char_a;
	system_pkg::rgb_t sprite_rgb;
	logic sprite_a;
	system_pkg::rgb_t tile_rgb;
	logic tile_a;
	logic [7:0] star_grey;
	logic pause_system;
	logic [7:0] vga_r;
	logic [7:0] vga_g;
	logic [7:0] vga_b;

	// testbench copies of the random input words
	logic [191:0] joy_v;
	logic [255:0] analog_v;
	logic [95:0] spin_v;
	logic [10:0] snd_v [4];

	// operation table, one entry per row in each queue
	int row_kind [$];
	logic [15:0] row_addr [$];
	logic [7:0] row_data [$];
	logic [7:0] row_expect [$];

	// byte offsets tried per page, some past the end or aliased
	int joy_idx [6] = '{0, 7, 23, 24, 31, 55};
	int analog_idx [4] = '{0, 13, 31, 18};
	int spin_idx [6] = '{0, 5, 11, 12, 15, 49};
	logic [7:0] snd_page [4] = '{8'h86, 8'h87, 8'h88, 8'h89};

	logic [31:0] rng_state = 32'h1ba3;
	int checks_done = 0;
	int errors = 0;
	int watchdog_cycles = 0;

	system_core #(
		.pgrom_addr_bits(15),
		.wkram_addr_bits(14)
	) dut (.*);

	bind system_core system_core_assertions u_assertions (
		.clk_24(clk_24),
		.arst_n(arst_n),
		.cpu_addr(cpu_addr),
		.cpu_din(cpu_din),
		.pause(pause),
		.pause_system(pause_system),
		.hb(hb),
		.vb(vb),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b)
	);

	initial
	begin
		clk_24 = 1'b0;
		forever
			#(clk_period / 2) clk_24 = ~clk_24;
	end

	// run limit grows with the table
	initial
	begin
		wait (watchdog_cycles != 0);
		#(watchdog_cycles * clk_period);
		$display("timeout: the table did not finish within %0d cycles", watchdog_cycles);
		$display(">>> FAIL");
		$fatal(1, "watchdog expired");
	end

	// xorshift32
	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// byte idx of a packed word, zero past nbytes
	function automatic logic [7:0] word_byte(input logic [255:0] w, input int nbytes, input int idx);
		if (idx < nbytes)
			return w[idx*8 +: 8];
		return 8'h00;
	endfunction

	// high byte keeps only bits 10..8
	function automatic logic [7:0] sound_expect(input logic [10:0] w, input logic hi);
		return hi ? {5'b00000, w[10:8]} : w[7:0];
	endfunction

	function automatic logic [23:0] mix_expect(
		input logic slh,
		input logic [23:0] c,
		input logic ca,
		input logic [23:0] s,
		input logic sa,
		input logic [23:0] t,
		input logic ta,
		input logic [7:0] g,
		input logic blank
	);
		if (blank)
			return 24'h0;
		// sprites only jump the queue when raised
		if (slh && sa)
			return s;
		if (ca)
			return c;
		if (sa)
			return s;
		if (ta)
			return t;
		return {g, g, g};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] expected);
		checks_done++;
		if (got !== expected)
		begin
			errors++;
			$display("FAILED at %0t ns: %s = %0h, expected %0h", $time, name, got, expected);
			$display(">>> FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic add_row(input int kind, input logic [15:0] addr, input logic [7:0] data,
		input logic [7:0] expected);
		row_kind.push_back(kind);
		row_addr.push_back(addr);
		row_data.push_back(data);
		row_expect.push_back(expected);
	endtask

	// one write strobe, taken at the second edge
	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk_24);
		cpu_addr <= addr;
		cpu_dout <= data;
		cpu_wr_n <= 1'b0;
		@(posedge clk_24);
		cpu_wr_n <= 1'b1;
	endtask

	// address seen at one edge, data checked after the next
	task automatic cpu_read_check(input logic [15:0] addr, input logic [7:0] expected);
		@(posedge clk_24);
		cpu_addr <= addr;
		cpu_wr_n <= 1'b1;
		@(posedge clk_24);
		@(negedge clk_24);
		check_value("cpu_din", {24'h0, cpu_din}, {24'h0, expected});
	endtask

	task automatic rom_download(input logic [7:0] index, input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk_24);
		dn_wr <= 1'b1;
		dn_index <= index;
		dn_addr <= {1'b0, addr};
		dn_data <= data;
		@(posedge clk_24);
		dn_wr <= 1'b0;
	endtask

	task automatic pulse_pause();
		@(posedge clk_24);
		pause <= 1'b1;
		@(posedge clk_24);
		pause <= 1'b0;
	endtask

	task automatic pulse_menu();
		@(posedge clk_24);
		menu <= 1'b1;
		@(posedge clk_24);
		menu <= 1'b0;
	endtask

	task automatic pause_check(input logic expected);
		@(negedge clk_24);
		check_value("pause_system", {31'h0, pause_system}, {31'h0, expected});
	endtask

	task automatic set_poly(input logic value);
		@(posedge clk_24);
		poly_en <= value;
	endtask

	// sync levels as hs, vs, hb, vb and the menu button level
	task automatic set_status_inputs(input logic [3:0] sync, input logic menu_level);
		@(posedge clk_24);
		hs <= sync[3];
		vs <= sync[2];
		hb <= sync[1];
		vb <= sync[0];
		menu <= menu_level;
	endtask

	// fresh random layers, mixer output checked in the same cycle
	task automatic mix_check(input logic slh, input logic h_blank, input logic v_blank);
		logic [31:0] alpha;
		logic [31:0] c;
		logic [31:0] s;
		logic [31:0] t;
		logic [31:0] g;
		logic [23:0] expected;
		alpha = next_rand();
		c = next_rand();
		s = next_rand();
		t = next_rand();
		g = next_rand();
		@(posedge clk_24);
		char_rgb <= c[23:0];
		sprite_rgb <= s[23:0];
		tile_rgb <= t[23:0];
		star_grey <= g[7:0];
		char_a <= alpha[3];
		sprite_a <= alpha[9];
		tile_a <= alpha[17];
		hb <= h_blank;
		vb <= v_blank;
		@(negedge clk_24);
		expected = mix_expect(slh, c[23:0], alpha[3], s[23:0], alpha[9], t[23:0], alpha[17],
			g[7:0], h_blank || v_blank);
		check_value("vga {b,g,r}", {8'h0, vga_b, vga_g, vga_r}, {8'h0, expected});
	endtask

	initial
	begin
		// every input defined before the first edge
		arst_n = 1'b0;
		cpu_addr = 16'h9000;
		cpu_dout = 8'h00;
		cpu_wr_n = 1'b1;
		dn_wr = 1'b0;
		dn_index = 8'h00;
		dn_addr = 17'h0;
		dn_data = 8'h00;
		pause = 1'b0;
		menu = 1'b0;
		poly_en = 1'b0;
		joystick = '0;
		analog_l = '0;
		spinner = '0;
		sq1 = '0;
		sq2 = '0;
		wave = '0;
		noise = '0;
		{hs, vs, hb, vb} = sync_idle;
		char_rgb = '0;
		char_a = 1'b0;
		sprite_rgb = '0;
		sprite_a = 1'b0;
		tile_rgb = '0;
		tile_a = 1'b0;
		star_grey = 8'h00;

		repeat (2) @(posedge clk_24);
		arst_n <= 1'b1;

		// random input words
		for (int k = 0; k < 6; k++)
			joy_v[k*32 +: 32] = next_rand();
		for (int k = 0; k < 8; k++)
			analog_v[k*32 +: 32] = next_rand();
		for (int k = 0; k < 3; k++)
			spin_v[k*32 +: 32] = next_rand();
		for (int k = 0; k < 4; k++)
			snd_v[k] = 11'(next_rand());
		@(posedge clk_24);
		joystick <= joy_v;
		analog_l <= analog_v;
		spinner <= spin_v;
		sq1 <= snd_v[0];
		sq2 <= snd_v[1];
		wave <= snd_v[2];
		noise <= snd_v[3];

		// reset state
		add_row(k_pause_check, 16'h0, 8'h00, 8'h00);
		add_row(k_read, 16'h8A31, 8'h00, 8'h00);
		// work ram
		add_row(k_write, 16'hC000, 8'h3C, 8'h00);
		add_row(k_write, 16'hC123, 8'hA7, 8'h00);
		add_row(k_write, 16'hFFFF, 8'h81, 8'h00);
		add_row(k_read, 16'hC000, 8'h00, 8'h3C);
		add_row(k_read, 16'hFFFF, 8'h00, 8'h81);
		add_row(k_read, 16'hC123, 8'h00, 8'hA7);
		add_row(k_write, 16'hC123, 8'h5E, 8'h00);
		add_row(k_read, 16'hC123, 8'h00, 8'h5E);
		// program rom through the download port
		add_row(k_load, 16'h0000, 8'h11, 8'h00);
		add_row(k_load, 16'h1234, 8'hC9, 8'h00);
		add_row(k_load, 16'h7FFF, 8'hE4, 8'h00);
		add_row(k_load_other, 16'h1234, 8'h00, 8'h00);
		add_row(k_read, 16'h1234, 8'h00, 8'hC9);
		add_row(k_read, 16'h0000, 8'h00, 8'h11);
		add_row(k_read, 16'h7FFF, 8'h00, 8'hE4);
		// input pages
		foreach (joy_idx[i])
			add_row(k_read, 16'h8100 | 16'(joy_idx[i]), 8'h00,
				word_byte({64'h0, joy_v}, 24, joy_idx[i] % 32));
		foreach (analog_idx[i])
			add_row(k_read, 16'h8200 | 16'(analog_idx[i]), 8'h00,
				word_byte(analog_v, 32, analog_idx[i] % 64));
		foreach (spin_idx[i])
			add_row(k_read, 16'h8500 | 16'(spin_idx[i]), 8'h00,
				word_byte({160'h0, spin_v}, 12, spin_idx[i] % 16));
		for (int p = 0; p < 4; p++)
			for (int lo = 0; lo < 2; lo++)
				add_row(k_read, {snd_page[p], 8'h00} | 16'(lo), 8'h00,
					sound_expect(snd_v[p], lo == 1));
		// status byte, menu input low
		add_row(k_read, 16'h8000, 8'h00, {sync_idle, 1'b1, 1'b0, 1'b0, 1'b0});
		add_row(k_read, 16'h8A32, 8'h00, 8'h00);
		add_row(k_poly, 16'h0, 8'h01, 8'h00);
		add_row(k_read, 16'h8A32, 8'h00, 8'hFF);
		// quiet addresses
		add_row(k_read, 16'h9000, 8'h00, 8'h00);
		add_row(k_read, 16'h8001, 8'h00, 8'h00);
		add_row(k_read, 16'h8A30, 8'h00, 8'h00);
		add_row(k_read, 16'h8300, 8'h00, 8'h00);
		add_row(k_read, 16'h8A33, 8'h00, 8'h00);
		add_row(k_read, 16'hA5A5, 8'h00, 8'h00);
		// pause trigger set by write, cleared by the pause input
		add_row(k_write, 16'h8A30, 8'h00, 8'h00);
		add_row(k_pause_check, 16'h0, 8'h00, 8'h01);
		// pause address stays quiet with the trigger set
		add_row(k_read, 16'h8A30, 8'h00, 8'h00);
		add_row(k_pause_pulse, 16'h0, 8'h00, 8'h00);
		add_row(k_pause_check, 16'h0, 8'h00, 8'h00);
		// menu trigger set by the button, cleared by write
		add_row(k_menu_pulse, 16'h0, 8'h00, 8'h00);
		add_row(k_read, 16'h8A31, 8'h00, 8'hFF);
		add_row(k_write, 16'h8A31, 8'h00, 8'h00);
		add_row(k_read, 16'h8A31, 8'h00, 8'h00);
		// status byte with other sync levels and the menu button held
		add_row(k_status_in, 16'h0, {4'b0101, 4'b0010}, 8'h00);
		add_row(k_read, 16'h8000, 8'h00, {4'b0101, 1'b1, 1'b0, 1'b1, 1'b0});
		add_row(k_status_in, 16'h0, {sync_idle, 4'b0000}, 8'h00);
		// layer mixing, chars on top, then sprites on top
		add_row(k_write, 16'h8001, 8'h00, 8'h00);
		for (int n = 0; n < 12; n++)
			add_row(k_mix, 16'h0, 8'h00, 8'h00);
		add_row(k_mix, 16'h0, 8'h02, 8'h00);
		add_row(k_mix, 16'h0, 8'h04, 8'h00);
		add_row(k_write, 16'h8001, 8'h01, 8'h00);
		for (int n = 0; n < 12; n++)
			add_row(k_mix, 16'h0, 8'h01, 8'h00);
		add_row(k_mix, 16'h0, 8'h03, 8'h00);
		add_row(k_mix, 16'h0, 8'h07, 8'h00);
		// only bit 0 matters
		add_row(k_write, 16'h8001, 8'hFE, 8'h00);
		// video control byte is write only
		add_row(k_read, 16'h8001, 8'h00, 8'h00);
		for (int n = 0; n < 4; n++)
			add_row(k_mix, 16'h0, 8'h00, 8'h00);

		watchdog_cycles = row_kind.size() * 20 + 100;

		for (int r = 0; r < row_kind.size(); r++)
		begin
			case (row_kind[r])
				k_write:
					cpu_write(row_addr[r], row_data[r]);
				k_read:
					cpu_read_check(row_addr[r], row_expect[r]);
				k_load:
					rom_download(8'd0, row_addr[r], row_data[r]);
				k_load_other:
					rom_download(8'd2, row_addr[r], row_data[r]);
				k_pause_pulse:
					pulse_pause();
				k_menu_pulse:
					pulse_menu();
				k_pause_check:
					pause_check(row_expect[r][0]);
				k_poly:
					set_poly(row_data[r][0]);
				k_mix:
					mix_check(row_data[r][0], row_data[r][1], row_data[r][2]);
				k_status_in:
					set_status_inputs(row_data[r][7:4], row_data[r][1]);
			endcase
			// a bound assertion fired during this row
			check_value("assertion failures", dut.u_assertions.failures, 0);
		end

		$display("%0d rows applied, %0d checks", row_kind.size(), checks_done);
		if (errors == 0 && checks_done > 0 && dut.u_assertions.failures == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
rtl/system_pkg.sv
rtl/address_decoder.sv
rtl/system_control.sv
rtl/memory_block.sv
rtl/cpu_read_mux.sv
rtl/layer_mixer.sv
rtl/system_core.sv
testbench/system_core_assertions.sv
testbench/tb_system_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_system_core
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps
SIM_ARGS ?= +verilator+error+limit+10

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '^>>> PASS$$' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
